// File: source/dcache_consts.svh
// Cache geometry and width macros, included by every RTL file that sizes ports or arrays.
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// 32 KB, 4 ways, 64 B lines
`define DC_SETS 128
`define DC_WAYS 4

// address split: tag 31..13, set 12..6, line offset 5..0
`define DC_SET_W 7
`define DC_TAG_W 19

// 8-byte data words, so eight refill beats per line
`define DC_BEATS 8

// data array index is {set, way, beat}
`define DC_INDEX_W 12

// load/store queue entry id
`define DC_LSQID_W 4

`endif

// File: source/dcache_pkg.sv
// Shared types for the data cache: LSQ operation codes and the miss FSM states.
package dcache_pkg;

  // bit 0 marks a store; bits 3..1 give width and signedness
  typedef enum logic [3:0] {
    op_lb  = 4'b0000,
    op_lh  = 4'b0010,
    op_lw  = 4'b0100,
    op_lbu = 4'b1000,
    op_lhu = 4'b1010,
    op_sb  = 4'b0001,
    op_sh  = 4'b0011,
    op_sw  = 4'b0101
  } mem_op_e;

  // one outstanding line miss
  typedef enum logic [1:0] {
    miss_idle    = 2'd0,
    miss_request = 2'd1,
    miss_refill  = 2'd2
  } miss_state_e;

endpackage

// File: source/dcache_data_array.sv
// Data array of the cache: 4096 x 64-bit words with a byte-masked write and a registered read.
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_data_array (
  input  logic                   clk,
  input  logic                   rd_en,
  input  logic [`DC_INDEX_W-1:0] rd_index,
  input  logic                   hit_wen,
  input  logic [`DC_INDEX_W-1:0] hit_windex,
  input  logic [7:0]             hit_wmask,
  input  logic [63:0]            hit_wdata,
  input  logic                   fill_wen,
  input  logic [`DC_INDEX_W-1:0] fill_windex,
  input  logic [63:0]            fill_wdata,
  output logic [63:0]            rd_data
);

  logic [63:0] mem [1 << `DC_INDEX_W];

  // refill beats write the full word, store hits only their bytes
  always_ff @(posedge clk) begin
    if (fill_wen) begin
      mem[fill_windex] <= fill_wdata;
    end else if (hit_wen) begin
      for (int b = 0; b < 8; b++) begin
        if (hit_wmask[b]) mem[hit_windex][b*8 +: 8] <= hit_wdata[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) rd_data <= mem[rd_index];
  end

endmodule

// File: source/dcache_load_align.sv
// Result stage: registers the issued load and aligns and extends the data array word.
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_load_align import dcache_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ld_issue,
  input  mem_op_e                ld_op,
  input  logic [2:0]             ld_offset,
  input  logic [`DC_LSQID_W-1:0] ld_lsqid,
  input  logic [63:0]            rd_data,
  output logic                   lsq_valid,
  output logic [`DC_LSQID_W-1:0] lsq_resp_lsqid,
  output logic [31:0]            lsq_rdata
);

  logic                   valid_r;
  mem_op_e                op_r;
  logic [2:0]             offset_r;
  logic [`DC_LSQID_W-1:0] lsqid_r;
  logic [31:0]            word;
  logic [31:0]            shifted;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_r <= 1'b0;
    end else begin
      valid_r <= ld_issue;
    end
  end

  // lines up with the data array read
  always_ff @(posedge clk) begin
    if (ld_issue) begin
      op_r     <= ld_op;
      offset_r <= ld_offset;
      lsqid_r  <= ld_lsqid;
    end
  end

  always_comb begin
    word    = offset_r[2] ? rd_data[63:32] : rd_data[31:0];
    shifted = word >> {offset_r[1:0], 3'b000};
    case (op_r)
      op_lb:   lsq_rdata = {{24{shifted[7]}}, shifted[7:0]};
      op_lh:   lsq_rdata = {{16{shifted[15]}}, shifted[15:0]};
      op_lbu:  lsq_rdata = {24'd0, shifted[7:0]};
      op_lhu:  lsq_rdata = {16'd0, shifted[15:0]};
      default: lsq_rdata = shifted;
    endcase
  end

  assign lsq_valid      = valid_r;
  assign lsq_resp_lsqid = lsqid_r;

endmodule

// File: source/dcache_miss_unit.sv
// Miss unit: drives the L2 port for line reads and store writes and sequences the refill.
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_miss_unit import dcache_pkg::*; (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          miss_start,
  input  logic [31:6]                   miss_line_addr,
  input  logic [$clog2(`DC_WAYS)-1:0]   miss_way,
  input  logic                          st_req,
  input  logic [31:2]                   st_addr,
  input  logic [3:0]                    st_wmask,
  input  logic [31:0]                   st_wdata,
  input  logic                          l2_ready,
  input  logic                          l2_valid,
  input  logic [63:0]                   l2_rdata,
  output logic                          miss_busy,
  output logic                          fill_done,
  output logic                          st_done,
  output logic                          l2_req,
  output logic [31:2]                   l2_addr,
  output logic                          l2_wen,
  output logic [3:0]                    l2_wmask,
  output logic [31:0]                   l2_wdata,
  output logic                          fill_wen,
  output logic [`DC_INDEX_W-1:0]        fill_windex,
  output logic [63:0]                   fill_wdata
);

  localparam int WAY_W  = $clog2(`DC_WAYS);
  localparam int BEAT_W = $clog2(`DC_BEATS);

  miss_state_e       state_r;
  logic [31:6]       line_r;
  logic [WAY_W-1:0]  way_r;
  logic [BEAT_W-1:0] beat_r;
  logic              fill_done_r;
  logic              line_sel;
  logic              last_beat;

  assign last_beat = beat_r == BEAT_W'(`DC_BEATS - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_r     <= miss_idle;
      beat_r      <= '0;
      fill_done_r <= 1'b0;
    end else begin
      fill_done_r <= 1'b0;
      case (state_r)
        miss_idle: begin
          if (miss_start) begin
            state_r <= miss_request;
            beat_r  <= '0;
          end
        end
        miss_request: begin
          if (l2_ready) state_r <= miss_refill;
        end
        miss_refill: begin
          if (l2_valid) begin
            beat_r <= beat_r + 1'b1;
            if (last_beat) begin
              state_r     <= miss_idle;
              fill_done_r <= 1'b1;
            end
          end
        end
        default: state_r <= miss_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_r == miss_idle && miss_start) begin
      line_r <= miss_line_addr;
      way_r  <= miss_way;
    end
  end

  // line read has the port first, the store waits
  assign line_sel = state_r == miss_request;
  assign st_done  = st_req && l2_ready && !line_sel;

  assign l2_req   = line_sel || st_req;
  assign l2_addr  = line_sel ? {line_r, 4'b0000} : st_addr;
  assign l2_wen   = !line_sel;
  assign l2_wmask = line_sel ? 4'b0000 : st_wmask;
  assign l2_wdata = st_wdata;

  // beats arrive in address order
  assign fill_wen    = state_r == miss_refill && l2_valid;
  assign fill_windex = {line_r[6 +: `DC_SET_W], way_r, beat_r};
  assign fill_wdata  = l2_rdata;

  assign fill_done = fill_done_r;
  // held through the fill_done cycle until the tag is written
  assign miss_busy = state_r != miss_idle || fill_done_r;

  a_beat_in_refill: assert property (@(posedge clk) disable iff (rst)
    l2_valid |-> state_r == miss_refill);

endmodule

// File: source/dcache_lookup.sv
// Lookup stage: holds the LSQ request, checks tags, picks refill ways and formats stores.
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_lookup import dcache_pkg::*; (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          lsq_req,
  input  mem_op_e                       lsq_op,
  input  logic [31:0]                   lsq_addr,
  input  logic [`DC_LSQID_W-1:0]        lsq_lsqid,
  input  logic [31:0]                   lsq_wdata,
  input  logic                          st_done,
  input  logic                          fill_done,
  input  logic                          miss_busy,
  output logic                          lsq_ready,
  output logic                          miss_start,
  output logic [31:6]                   miss_line_addr,
  output logic [$clog2(`DC_WAYS)-1:0]   miss_way,
  output logic                          st_req,
  output logic [31:2]                   st_addr,
  output logic [3:0]                    st_wmask,
  output logic [31:0]                   st_wdata,
  output logic                          rd_en,
  output logic [`DC_INDEX_W-1:0]        rd_index,
  output logic                          hit_wen,
  output logic [`DC_INDEX_W-1:0]        hit_windex,
  output logic [7:0]                    hit_wmask,
  output logic [63:0]                   hit_wdata,
  output logic                          ld_issue,
  output mem_op_e                       ld_op,
  output logic [2:0]                    ld_offset,
  output logic [`DC_LSQID_W-1:0]        ld_lsqid
);

  localparam int WAY_W = $clog2(`DC_WAYS);

  // tree bits: [2] picks the half, [1] the upper pair, [0] the lower pair
  function automatic logic [2:0] next_lru(input logic [WAY_W-1:0] way, input logic [2:0] lru);
    logic [2:0] upd;
    upd = lru;
    upd[2] = ~way[1];
    if (way[1]) begin
      upd[1] = ~way[0];
    end else begin
      upd[0] = ~way[0];
    end
    return upd;
  endfunction

  function automatic logic [WAY_W-1:0] plru_victim(input logic [2:0] lru);
    return lru[2] ? {1'b1, lru[1]} : {1'b0, lru[0]};
  endfunction

  // held request
  logic                   req_r;
  mem_op_e                op_r;
  logic [31:0]            addr_r;
  logic [`DC_LSQID_W-1:0] lsqid_r;
  logic [31:0]            wdata_r;

  // refill in flight for the held load
  logic                   miss_open_r;
  logic [WAY_W-1:0]       fill_way_r;

  logic [`DC_WAYS-1:0]    tag_valid [`DC_SETS];
  logic [2:0]             lru [`DC_SETS];
  logic [`DC_TAG_W-1:0]   tag_mem [`DC_SETS][`DC_WAYS];

  logic [`DC_SET_W-1:0]   set;
  logic [`DC_TAG_W-1:0]   tag;
  logic [`DC_WAYS-1:0]    way_hit;
  logic                   hit;
  logic [WAY_W-1:0]       hit_way;
  logic [WAY_W-1:0]       victim_way;
  logic                   is_store;
  logic                   ld_hit;
  logic [`DC_INDEX_W-1:0] word_index;
  logic [3:0]             wmask;
  logic [31:0]            wdata_rep;

  assign set = addr_r[6 +: `DC_SET_W];
  assign tag = addr_r[31 -: `DC_TAG_W];
  assign is_store = op_r inside {op_sb, op_sh, op_sw};

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      way_hit[w] = tag_valid[set][w] && (tag_mem[set][w] == tag);
      if (way_hit[w]) hit_way = WAY_W'(w);
    end
  end

  assign hit = |way_hit;

  // lowest invalid way wins over the tree
  always_comb begin
    victim_way = plru_victim(lru[set]);
    for (int w = `DC_WAYS - 1; w >= 0; w--) begin
      if (!tag_valid[set][w]) victim_way = WAY_W'(w);
    end
  end

  assign ld_hit = req_r && !is_store && hit;
  assign miss_start = req_r && !is_store && !hit && !miss_open_r;
  assign st_req = req_r && is_store;
  assign lsq_ready = !miss_busy && (!req_r || ld_hit || st_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      req_r <= 1'b0;
    end else if (lsq_ready) begin
      req_r <= lsq_req;
    end
  end

  always_ff @(posedge clk) begin
    if (lsq_ready && lsq_req) begin
      op_r    <= lsq_op;
      addr_r  <= lsq_addr;
      lsqid_r <= lsq_lsqid;
      wdata_r <= lsq_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      miss_open_r <= 1'b0;
    end else if (miss_start) begin
      miss_open_r <= 1'b1;
    end else if (fill_done) begin
      miss_open_r <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (miss_start) fill_way_r <= victim_way;
  end

  // valid and LRU state; the held load still owns addr_r during the refill
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `DC_SETS; s++) begin
        tag_valid[s] <= '0;
        lru[s]       <= '0;
      end
    end else begin
      if (fill_done) tag_valid[set][fill_way_r] <= 1'b1;
      if (ld_hit) begin
        lru[set] <= next_lru(hit_way, lru[set]);
      end else if (miss_start) begin
        lru[set] <= next_lru(victim_way, lru[set]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_done) tag_mem[set][fill_way_r] <= tag;
  end

  // byte lanes within the 32-bit word
  always_comb begin
    case (op_r)
      op_sb: begin
        wmask     = 4'b0001 << addr_r[1:0];
        wdata_rep = {4{wdata_r[7:0]}};
      end
      op_sh: begin
        wmask     = 4'b0011 << {addr_r[1], 1'b0};
        wdata_rep = {2{wdata_r[15:0]}};
      end
      default: begin
        wmask     = 4'b1111;
        wdata_rep = wdata_r;
      end
    endcase
  end

  assign word_index = {set, hit_way, addr_r[5:3]};

  assign miss_line_addr = addr_r[31:6];
  assign miss_way       = victim_way;
  assign st_addr        = addr_r[31:2];
  assign st_wmask       = wmask;
  assign st_wdata       = wdata_rep;

  assign rd_en    = ld_hit;
  assign rd_index = word_index;

  // store hit lands in the array on the edge L2 takes the write
  assign hit_wen    = st_done && hit;
  assign hit_windex = word_index;
  assign hit_wmask  = addr_r[2] ? {wmask, 4'b0000} : {4'b0000, wmask};
  assign hit_wdata  = {2{wdata_rep}};

  assign ld_issue  = ld_hit;
  assign ld_op     = op_r;
  assign ld_offset = addr_r[2:0];
  assign ld_lsqid  = lsqid_r;

  a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
    req_r |-> $onehot0(way_hit));

  // own miss tracking must agree with the miss unit
  a_no_double_miss: assert property (@(posedge clk) disable iff (rst)
    miss_start |-> !miss_busy);

endmodule

// File: source/dcache.sv
// Data cache top level, connecting lookup, miss unit, data array and load alignment.
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache import dcache_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  // load/store queue
  input  logic                   lsq_req,
  input  mem_op_e                lsq_op,
  input  logic [31:0]            lsq_addr,
  input  logic [`DC_LSQID_W-1:0] lsq_lsqid,
  input  logic [31:0]            lsq_wdata,
  output logic                   lsq_ready,
  output logic                   lsq_valid,
  output logic [`DC_LSQID_W-1:0] lsq_resp_lsqid,
  output logic [31:0]            lsq_rdata,
  // L2
  output logic                   l2_req,
  output logic [31:2]            l2_addr,
  output logic                   l2_wen,
  output logic [3:0]             l2_wmask,
  output logic [31:0]            l2_wdata,
  input  logic                   l2_ready,
  input  logic                   l2_valid,
  input  logic [63:0]            l2_rdata
);

  localparam int WAY_W = $clog2(`DC_WAYS);

  logic                   miss_start;
  logic [31:6]            miss_line_addr;
  logic [WAY_W-1:0]       miss_way;
  logic                   miss_busy;
  logic                   fill_done;
  logic                   st_req;
  logic [31:2]            st_addr;
  logic [3:0]             st_wmask;
  logic [31:0]            st_wdata;
  logic                   st_done;
  logic                   rd_en;
  logic [`DC_INDEX_W-1:0] rd_index;
  logic [63:0]            rd_data;
  logic                   hit_wen;
  logic [`DC_INDEX_W-1:0] hit_windex;
  logic [7:0]             hit_wmask;
  logic [63:0]            hit_wdata;
  logic                   fill_wen;
  logic [`DC_INDEX_W-1:0] fill_windex;
  logic [63:0]            fill_wdata;
  logic                   ld_issue;
  mem_op_e                ld_op;
  logic [2:0]             ld_offset;
  logic [`DC_LSQID_W-1:0] ld_lsqid;

  dcache_lookup i_lookup (
    .clk(clk), .rst(rst),
    .lsq_req(lsq_req), .lsq_op(lsq_op), .lsq_addr(lsq_addr),
    .lsq_lsqid(lsq_lsqid), .lsq_wdata(lsq_wdata),
    .st_done(st_done), .fill_done(fill_done), .miss_busy(miss_busy),
    .lsq_ready(lsq_ready),
    .miss_start(miss_start), .miss_line_addr(miss_line_addr), .miss_way(miss_way),
    .st_req(st_req), .st_addr(st_addr), .st_wmask(st_wmask), .st_wdata(st_wdata),
    .rd_en(rd_en), .rd_index(rd_index),
    .hit_wen(hit_wen), .hit_windex(hit_windex), .hit_wmask(hit_wmask),
    .hit_wdata(hit_wdata),
    .ld_issue(ld_issue), .ld_op(ld_op), .ld_offset(ld_offset), .ld_lsqid(ld_lsqid)
  );

  dcache_miss_unit i_miss_unit (
    .clk(clk), .rst(rst),
    .miss_start(miss_start), .miss_line_addr(miss_line_addr), .miss_way(miss_way),
    .st_req(st_req), .st_addr(st_addr), .st_wmask(st_wmask), .st_wdata(st_wdata),
    .l2_ready(l2_ready), .l2_valid(l2_valid), .l2_rdata(l2_rdata),
    .miss_busy(miss_busy), .fill_done(fill_done), .st_done(st_done),
    .l2_req(l2_req), .l2_addr(l2_addr), .l2_wen(l2_wen), .l2_wmask(l2_wmask),
    .l2_wdata(l2_wdata),
    .fill_wen(fill_wen), .fill_windex(fill_windex), .fill_wdata(fill_wdata)
  );

  dcache_data_array i_data_array (
    .clk(clk),
    .rd_en(rd_en), .rd_index(rd_index),
    .hit_wen(hit_wen), .hit_windex(hit_windex), .hit_wmask(hit_wmask),
    .hit_wdata(hit_wdata),
    .fill_wen(fill_wen), .fill_windex(fill_windex), .fill_wdata(fill_wdata),
    .rd_data(rd_data)
  );

  dcache_load_align i_load_align (
    .clk(clk), .rst(rst),
    .ld_issue(ld_issue), .ld_op(ld_op), .ld_offset(ld_offset), .ld_lsqid(ld_lsqid),
    .rd_data(rd_data),
    .lsq_valid(lsq_valid), .lsq_resp_lsqid(lsq_resp_lsqid), .lsq_rdata(lsq_rdata)
  );

endmodule

// File: testbench/dcache_checker.sv
// Testbench checker: compares load responses and L2 writes with expected values, counts tests.
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_checker (
  input logic                   clk,
  input logic                   rst,
  input logic                   lsq_valid,
  input logic [`DC_LSQID_W-1:0] lsq_resp_lsqid,
  input logic [31:0]            lsq_rdata,
  input logic                   l2_req,
  input logic                   l2_ready,
  input logic [31:2]            l2_addr,
  input logic                   l2_wen,
  input logic [3:0]             l2_wmask,
  input logic [31:0]            l2_wdata
);

  logic [`DC_LSQID_W-1:0] exp_lsqid_q [$];
  logic [31:0]            exp_rdata_q [$];
  logic [31:2]            exp_st_addr_q [$];
  logic [3:0]             exp_st_mask_q [$];
  logic [31:0]            exp_st_data_q [$];
  int errors = 0;
  int test_errors = 0;
  int tests = 0;
  int failed_tests = 0;
  int line_reads = 0;

  task automatic expect_load(input logic [`DC_LSQID_W-1:0] id, input logic [31:0] rdata);
    exp_lsqid_q.push_back(id);
    exp_rdata_q.push_back(rdata);
  endtask

  task automatic expect_store(input logic [31:2] addr, input logic [3:0] mask,
                              input logic [31:0] data);
    exp_st_addr_q.push_back(addr);
    exp_st_mask_q.push_back(mask);
    exp_st_data_q.push_back(data);
  endtask

  function automatic int outstanding();
    return exp_rdata_q.size() + exp_st_addr_q.size();
  endfunction

  function automatic int error_count();
    return errors;
  endfunction

  task automatic flag_error();
    errors++;
    test_errors++;
  endtask

  always @(posedge clk) begin
    if (!rst && lsq_valid) begin
      if (exp_rdata_q.size() == 0) begin
        $display("load response with lsqid %0d arrived but no load was pending", lsq_resp_lsqid);
        flag_error();
      end else begin
        if (lsq_resp_lsqid !== exp_lsqid_q[0]) begin
          $display("MISMATCH lsq_resp_lsqid: expected %h, got %h", exp_lsqid_q[0],
                   lsq_resp_lsqid);
          flag_error();
        end
        if (lsq_rdata !== exp_rdata_q[0]) begin
          $display("MISMATCH lsq_rdata: expected %h, got %h", exp_rdata_q[0], lsq_rdata);
          flag_error();
        end
        void'(exp_lsqid_q.pop_front());
        void'(exp_rdata_q.pop_front());
      end
    end
    // one accepted L2 request per edge
    if (!rst && l2_req && l2_ready) begin
      if (!l2_wen) begin
        line_reads++;
        if (l2_addr[5:2] != 4'd0) begin
          $display("line read at word address %h is not at a line base", l2_addr);
          flag_error();
        end
      end else if (exp_st_addr_q.size() == 0) begin
        $display("L2 write to word address %h with no store pending", l2_addr);
        flag_error();
      end else begin
        if (l2_addr !== exp_st_addr_q[0]) begin
          $display("MISMATCH l2_addr: expected %h, got %h", exp_st_addr_q[0], l2_addr);
          flag_error();
        end
        if (l2_wmask !== exp_st_mask_q[0]) begin
          $display("MISMATCH l2_wmask: expected %h, got %h", exp_st_mask_q[0], l2_wmask);
          flag_error();
        end
        if (l2_wdata !== exp_st_data_q[0]) begin
          $display("MISMATCH l2_wdata: expected %h, got %h", exp_st_data_q[0], l2_wdata);
          flag_error();
        end
        void'(exp_st_addr_q.pop_front());
        void'(exp_st_mask_q.pop_front());
        void'(exp_st_data_q.pop_front());
      end
    end
  end

  task automatic end_test(input int num, input int exp_reads);
    if (line_reads != exp_reads) begin
      $display("MISMATCH line_reads: expected %h, got %h", exp_reads, line_reads);
      flag_error();
    end
    tests++;
    if (test_errors != 0) failed_tests++;
    $display("test %0d: %s, %0d line reads, %0d errors", num,
             (test_errors == 0) ? "pass" : "fail", line_reads, test_errors);
    line_reads = 0;
    test_errors = 0;
  endtask

  task automatic report();
    $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
  endtask

endmodule

// File: testbench/tb_dcache.sv
// Top-level testbench of the data cache: runs the trace file against the DUT and an L2 model.
`timescale 1ns/1ns
`include "dcache_consts.svh"

module tb_dcache import dcache_pkg::*; ();

  localparam int          CLK_PERIOD = 100;
  localparam logic [31:0] SEED = 32'h5cdb_6b8e;

  logic clk, rst;
  logic lsq_req, lsq_ready, lsq_valid;
  mem_op_e lsq_op;
  logic [31:0] lsq_addr, lsq_wdata, lsq_rdata;
  logic [`DC_LSQID_W-1:0] lsq_lsqid, lsq_resp_lsqid;
  logic l2_req, l2_wen, l2_ready, l2_valid;
  logic [31:2] l2_addr;
  logic [3:0] l2_wmask;
  logic [31:0] l2_wdata;
  logic [63:0] l2_rdata;

  // trace entries; an end entry keeps the expected line reads in exp_q
  bit          is_end_q [$];
  int          tnum_q [$];
  mem_op_e     op_q [$];
  logic [31:0] addr_q [$];
  logic [31:0] wdata_q [$];
  int          id_q [$];
  logic [31:0] exp_q [$];
  int n_lines = 0;
  bit trace_loaded = 0;
  bit load_error = 0;

  logic [31:0] l2_mem [logic [29:0]];

  dcache i_dut (.*);

  dcache_checker i_checker (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic bit op_from_name(input string name, output mem_op_e op);
    op = op_lw;
    if (name == "lb") op = op_lb;
    else if (name == "lh") op = op_lh;
    else if (name == "lbu") op = op_lbu;
    else if (name == "lhu") op = op_lhu;
    else if (name == "sb") op = op_sb;
    else if (name == "sh") op = op_sh;
    else if (name != "sw" && name != "lw") return 1'b0;
    else if (name == "sw") op = op_sw;
    return 1'b1;
  endfunction

  function automatic int access_bytes(input mem_op_e op);
    case (op)
      op_sb, op_lb, op_lbu: return 1;
      op_sh, op_lh, op_lhu: return 2;
      default: return 4;
    endcase
  endfunction

  // bytes touched within the addressed word, naturally aligned
  function automatic logic [3:0] byte_mask(input mem_op_e op, input logic [1:0] offs);
    logic [3:0] m;
    int size;
    int first;
    size = access_bytes(op);
    first = (int'(offs) / size) * size;
    m = '0;
    for (int b = 0; b < 4; b++) begin
      m[b] = (b >= first) && (b < first + size);
    end
    return m;
  endfunction

  // store data repeated in every lane of the word
  function automatic logic [31:0] lane_data(input mem_op_e op, input logic [31:0] d);
    logic [31:0] r;
    int size;
    size = access_bytes(op);
    for (int b = 0; b < 4; b++) begin
      r[b*8 +: 8] = d[(b % size)*8 +: 8];
    end
    return r;
  endfunction

  // untouched words hold their byte address xor a fixed pattern
  function automatic logic [31:0] mem_word(input logic [29:0] waddr);
    if (l2_mem.exists(waddr)) return l2_mem[waddr];
    return {waddr, 2'b00} ^ 32'ha5a5_0000;
  endfunction

  task automatic apply_store(input logic [29:0] waddr, input logic [3:0] mask,
                             input logic [31:0] data);
    logic [31:0] w;
    w = mem_word(waddr);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) w[b*8 +: 8] = data[b*8 +: 8];
    end
    l2_mem[waddr] = w;
  endtask

  // L2 model: takes requests on the rising edge, drives ready and beats on the falling edge
  initial begin
    logic [29:0] line_q [$];
    logic [29:0] base;
    logic [31:0] rng;
    int beat;
    int gap;
    bit busy;
    rng = SEED;
    busy = 1'b0;
    beat = 0;
    gap = 0;
    base = '0;
    l2_ready = 1'b0;
    l2_valid = 1'b0;
    l2_rdata = '0;
    forever begin
      @(posedge clk);
      if (!rst && l2_req && l2_ready) begin
        if (l2_wen) apply_store(l2_addr, l2_wmask, l2_wdata);
        else line_q.push_back(l2_addr);
      end
      @(negedge clk);
      rng = xorshift32(rng);
      l2_ready = rng[1:0] != 2'b00;
      l2_valid = 1'b0;
      if (busy) begin
        if (gap != 0) begin
          gap--;
        end else begin
          l2_rdata = {mem_word(base + 30'(2 * beat + 1)), mem_word(base + 30'(2 * beat))};
          l2_valid = 1'b1;
          beat++;
          busy = beat != 8;
          gap = int'(rng[9:8]);
        end
      end else if (line_q.size() != 0) begin
        base = line_q.pop_front();
        busy = 1'b1;
        beat = 0;
        gap = int'(rng[9:8]);
      end
    end
  end

  task automatic issue(input mem_op_e op, input logic [31:0] addr, input logic [31:0] wdata,
                       input int id, input logic [31:0] exp_rdata);
    lsq_req = 1'b1;
    lsq_op = op;
    lsq_addr = addr;
    lsq_wdata = wdata;
    lsq_lsqid = `DC_LSQID_W'(id);
    // a store reaches L2 on the same edge that accepts it
    if (op inside {op_sb, op_sh, op_sw}) begin
      i_checker.expect_store(addr[31:2], byte_mask(op, addr[1:0]), lane_data(op, wdata));
    end else begin
      i_checker.expect_load(`DC_LSQID_W'(id), exp_rdata);
    end
    @(posedge clk);
    while (!lsq_ready) @(posedge clk);
    @(negedge clk);
    lsq_req = 1'b0;
  endtask

  initial begin
    int fd, code, t, n, id;
    string tok, opname, rest;
    logic [31:0] a, w, e;
    mem_op_e op;
    rst = 1'b1;
    lsq_req = 1'b0;
    lsq_op = op_lw;
    lsq_addr = '0;
    lsq_wdata = '0;
    lsq_lsqid = '0;
    fd = $fopen("testbench/dcache_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file testbench/dcache_trace.txt");
      load_error = 1'b1;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) break;
        if (tok.substr(0, 0) == "#") begin
          code = $fgets(rest, fd);
        end else if (tok == "end") begin
          code = $fscanf(fd, "%d %d", t, n);
          is_end_q.push_back(1'b1);
          tnum_q.push_back(t);
          op_q.push_back(op_lw);
          addr_q.push_back('0);
          wdata_q.push_back('0);
          id_q.push_back(0);
          exp_q.push_back(32'(n));
          n_lines++;
        end else begin
          code = $fscanf(fd, "%s %h %h %d %h", opname, a, w, id, e);
          if (!op_from_name(opname, op)) begin
            $display("unknown operation %s in the trace file", opname);
            load_error = 1'b1;
          end
          is_end_q.push_back(1'b0);
          tnum_q.push_back(tok.atoi());
          op_q.push_back(op);
          addr_q.push_back(a);
          wdata_q.push_back(w);
          id_q.push_back(id);
          exp_q.push_back(e);
          n_lines++;
        end
      end
      $fclose(fd);
    end
    trace_loaded = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < is_end_q.size(); i++) begin
      if (is_end_q[i]) begin
        while (i_checker.outstanding() != 0) @(negedge clk);
        i_checker.end_test(tnum_q[i], int'(exp_q[i]));
      end else begin
        issue(op_q[i], addr_q[i], wdata_q[i], id_q[i], exp_q[i]);
      end
    end
    i_checker.report();
    if (load_error || i_checker.error_count() != 0) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST OK");
    end
    $finish;
  end

  // budget of 40 cycles per trace line, plus the reset cycles
  initial begin
    wait (trace_loaded);
    #((n_lines + 4) * 40 * CLK_PERIOD);
    $display("timeout: the trace did not finish within %0d cycles", (n_lines + 4) * 40);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: project.f
+incdir+source
source/dcache_pkg.sv
source/dcache_data_array.sv
source/dcache_load_align.sv
source/dcache_miss_unit.sv
source/dcache_lookup.sv
source/dcache.sv
testbench/dcache_checker.sv
testbench/tb_dcache.sv

// File: run.sh
#!/bin/sh
# Builds the data cache testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_dcache -o sim_dcache

./obj_dir/sim_dcache > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0

// File: testbench/dcache_trace.txt
# columns: test op addr(hex) wdata(hex) lsqid expected_rdata(hex, loads only)
# a line "end test line_reads" closes a test with its expected L2 line reads
1 lw  00001000 00000000 0 a5a51000
1 lb  00001002 00000000 1 ffffffa5
1 lbu 00001002 00000000 2 000000a5
1 lh  00001002 00000000 3 ffffa5a5
1 lhu 00001002 00000000 4 0000a5a5
1 lb  00001001 00000000 5 00000010
1 lh  00001004 00000000 6 00001004
1 lbu 00001007 00000000 7 000000a5
1 lw  00001000 00000000 8 a5a51000
end 1 1
2 lw  00002048 00000000 9 a5a52048
2 lw  00002078 00000000 10 a5a52078
2 lhu 0000207e 00000000 11 0000a5a5
end 2 1
3 sb  00001001 0000005a 12 00000000
3 sh  00001006 0000beef 13 00000000
3 lw  00001000 00000000 14 a5a55a00
3 lw  00001004 00000000 15 beef1004
3 lh  00001006 00000000 0 ffffbeef
end 3 0
4 sw  00003080 12345678 1 00000000
4 sb  00003085 0000009c 2 00000000
4 lw  00003080 00000000 3 12345678
4 lbu 00003085 00000000 4 0000009c
4 lb  00003085 00000000 5 ffffff9c
4 lw  00003084 00000000 6 a5a59c84
end 4 1
5 lw  000000c0 00000000 7 a5a500c0
5 lw  000020c0 00000000 8 a5a520c0
5 lw  000040c0 00000000 9 a5a540c0
5 lw  000060c0 00000000 10 a5a560c0
5 lw  000000c0 00000000 11 a5a500c0
5 lw  000040c0 00000000 12 a5a540c0
5 lw  000080c0 00000000 13 a5a580c0
5 lw  000000c0 00000000 14 a5a500c0
5 lw  000020c0 00000000 15 a5a520c0
end 5 6
6 sw  00004140 deadbeef 0 00000000
6 lw  00004140 00000000 1 deadbeef
6 sh  00004142 00000bad 2 00000000
6 lw  00004140 00000000 3 0badbeef
6 sb  00004140 00000077 4 00000000
6 lbu 00004140 00000000 5 00000077
6 lh  00004142 00000000 6 00000bad
6 lw  00005184 00000000 7 a5a55184
6 lw  00004144 00000000 8 a5a54144
6 lw  00004140 00000000 9 0badbe77
end 6 2
